// File: test/memctrl_patterns.txt
# op (1 lookup, 2 write, 3 refill) set tag word wr_data wr_be refill_line exp_hit exp_data rnd
# rnd=1: refill line from $random, or lookup data taken from the testbench line mirror
1 f 5a 3 00000000 0 0 0 00000000 0
1 0 00 0 00000000 0 0 0 00000000 0
3 3 a0 0 00000000 0 a0000003a0000002a0000001a0000000 0 00000000 0
3 3 a1 0 00000000 0 a1000003a1000002a1000001a1000000 0 00000000 0
3 3 a2 0 00000000 0 0 0 00000000 1
3 3 a3 0 00000000 0 a3000003a3000002a3000001a3000000 0 00000000 0
1 3 a0 1 00000000 0 0 1 a0000001 0
1 3 a1 2 00000000 0 0 2 a1000002 0
1 3 a2 3 00000000 0 0 4 00000000 1
1 3 a3 0 00000000 0 0 8 a3000000 0
3 3 a4 0 00000000 0 a4000003a4000002a4000001a4000000 0 00000000 0
3 3 a5 0 00000000 0 0 0 00000000 1
1 3 a0 0 00000000 0 0 0 00000000 0
1 3 a4 2 00000000 0 0 1 a4000002 0
1 3 a5 1 00000000 0 0 2 00000000 1
1 3 a1 0 00000000 0 0 0 00000000 0
1 3 a3 1 00000000 0 0 8 a3000001 0
2 3 00 1 11223344 5 0 0 00000000 0
1 3 a3 1 00000000 0 0 8 a3220044 0
3 9 5c 0 00000000 0 5c0000035c0000025c0000015c000000 0 00000000 0
1 3 99 1 00000000 0 0 0 00000000 0
2 3 00 1 ffffffff f 0 0 00000000 0
1 3 a3 1 00000000 0 0 8 a3220044 0
1 9 5c 2 00000000 0 0 1 5c000002 0
1 3 a4 3 00000000 0 0 1 a4000003 0

// File: project.f
logic/memctrl_pkg.sv
logic/cache_sram.sv
logic/memctrl_fsm.sv
logic/victim_select.sv
logic/dir_ctrl.sv
logic/data_ctrl.sv
logic/cache_memctrl_top.sv
test/tb_cache_memctrl.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator and run; the exit status carries the test result
cd "$(dirname "$0")" &&
verilator --binary --timing -f project.f --top-module tb_cache_memctrl -o tb_cache_memctrl &&
./obj_dir/tb_cache_memctrl || exit 1

// File: test/tb_cache_memctrl.sv
// Self-checking testbench for the cache controller that replays the command patterns file
`timescale 1ns/1ps
`default_nettype none

module tb_cache_memctrl
    import memctrl_pkg::*;
();

    localparam int CLK_PERIOD = 20;
    localparam int MAX_PAT    = 64;
    localparam logic [3:0] OP_LOOKUP = 4'd1;
    localparam logic [3:0] OP_WRITE  = 4'd2;
    localparam logic [3:0] OP_REFILL = 4'd3;

    logic       clk, rst_n, ready, lookup, write, refill;
    set_t       set_idx;
    tag_t       tag;
    word_idx_t  word_idx;
    data_word_t wr_data, rd_data;
    word_be_t   wr_be;
    line_t      refill_line;
    way_vec_t   hit_way;

    // Pattern table with one entry per file line
    logic [3:0] pat_op    [MAX_PAT];
    set_t       pat_set   [MAX_PAT];
    tag_t       pat_tag   [MAX_PAT];
    word_idx_t  pat_word  [MAX_PAT];
    data_word_t pat_wdata [MAX_PAT];
    word_be_t   pat_be    [MAX_PAT];
    line_t      pat_line  [MAX_PAT];
    way_vec_t   pat_hit   [MAX_PAT];
    data_word_t pat_data  [MAX_PAT];
    logic       pat_rnd   [MAX_PAT];
    int         num_pat;
    logic       loaded;

    // Line mirror with valid bits and round-robin pointers per set
    line_t    mirror [NUM_SETS][NUM_WAYS];
    way_vec_t vld    [NUM_SETS];
    int       rr     [NUM_SETS];
    way_vec_t last_hit;
    integer   seed;

    cache_memctrl_top UUT (
        .clk_i         (clk),
        .rst_ni        (rst_n),
        .ready_o       (ready),
        .lookup_i      (lookup),
        .write_i       (write),
        .refill_i      (refill),
        .set_i         (set_idx),
        .tag_i         (tag),
        .word_i        (word_idx),
        .wr_data_i     (wr_data),
        .wr_be_i       (wr_be),
        .refill_line_i (refill_line),
        .hit_way_o     (hit_way),
        .rd_data_o     (rd_data)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_way(input string name, input int idx, input way_vec_t got,
                             input way_vec_t exp);
        if (got !== exp) begin
            $display("mismatch %s at pattern %0d: got 0x%h expected 0x%h", name, idx, got, exp);
            abort_run();
        end
    endtask

    task automatic check_data(input string name, input int idx, input data_word_t got,
                              input data_word_t exp);
        if (got !== exp) begin
            $display("mismatch %s at pattern %0d: got 0x%h expected 0x%h", name, idx, got, exp);
            abort_run();
        end
    endtask

    task automatic check_ready(input string name, input int idx, input logic got,
                               input logic exp);
        if (got !== exp) begin
            $display("mismatch %s at pattern %0d: got 0x%h expected 0x%h", name, idx, got, exp);
            abort_run();
        end
    endtask

    task automatic load_patterns();
        int         fd;
        int         n;
        string      text;
        logic [3:0] op;
        set_t       s;
        tag_t       t;
        word_idx_t  w;
        data_word_t d, x;
        word_be_t   be;
        line_t      ln;
        way_vec_t   h;
        logic       r;
        fd = $fopen("test/memctrl_patterns.txt", "r");
        if (fd == 0) begin
            $display("cannot open the pattern file test/memctrl_patterns.txt");
            abort_run();
        end
        num_pat = 0;
        while ($fgets(text, fd) != 0) begin
            // Skip column notes and blank lines
            if (text.len() < 2 || text.getc(0) == "#") continue;
            n = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h", op, s, t, w, d, be, ln, h, x, r);
            if (n != 10 || num_pat >= MAX_PAT) begin
                $display("pattern file line %0d could not be read", num_pat);
                abort_run();
            end
            pat_op[num_pat]    = op;
            pat_set[num_pat]   = s;
            pat_tag[num_pat]   = t;
            pat_word[num_pat]  = w;
            pat_wdata[num_pat] = d;
            pat_be[num_pat]    = be;
            pat_line[num_pat]  = ln;
            pat_hit[num_pat]   = h;
            pat_data[num_pat]  = x;
            pat_rnd[num_pat]   = r;
            num_pat++;
        end
        $fclose(fd);
    endtask

    // Takes the lowest invalid way or else the round-robin way of the set
    task automatic place_refill_line(input set_t s, input line_t ln);
        int way;
        way = -1;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!vld[s][w]) way = w;
        end
        if (way < 0) begin
            way = rr[s];
            rr[s] = (rr[s] + 1) % NUM_WAYS;
        end
        vld[s][way] = 1'b1;
        mirror[s][way] = ln;
    endtask

    task automatic merge_write_bytes(input set_t s, input word_idx_t wd, input data_word_t d,
                                     input word_be_t be);
        for (int w = 0; w < NUM_WAYS; w++) begin
            for (int b = 0; b < WORD_W / 8; b++) begin
                if (last_hit[w] && be[b]) mirror[s][w][wd*WORD_W + b*8 +: 8] = d[b*8 +: 8];
            end
        end
    endtask

    function automatic data_word_t mirror_word(input set_t s, input way_vec_t h,
                                               input word_idx_t wd);
        data_word_t res;
        res = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (h[w]) res = mirror[s][w][wd*WORD_W +: WORD_W];
        end
        return res;
    endfunction

    task automatic run_pattern(input int i);
        line_t      ln;
        data_word_t exp_data;
        ln       = pat_line[i];
        set_idx  = pat_set[i];
        tag      = pat_tag[i];
        word_idx = pat_word[i];
        wr_data  = pat_wdata[i];
        wr_be    = pat_be[i];
        case (pat_op[i])
            OP_LOOKUP: lookup = 1'b1;
            OP_WRITE: begin
                write = 1'b1;
                merge_write_bytes(pat_set[i], pat_word[i], pat_wdata[i], pat_be[i]);
            end
            OP_REFILL: begin
                if (pat_rnd[i]) ln = {$random(seed), $random(seed), $random(seed), $random(seed)};
                refill_line = ln;
                refill = 1'b1;
                place_refill_line(pat_set[i], ln);
                last_hit = '0;
            end
            default: begin
                $display("unknown operation code %0h in pattern %0d", pat_op[i], i);
                abort_run();
            end
        endcase
        @(posedge clk);
        #2;
        lookup = 1'b0;
        write  = 1'b0;
        refill = 1'b0;
        if (pat_op[i] == OP_LOOKUP) begin
            exp_data = pat_rnd[i] ? mirror_word(pat_set[i], pat_hit[i], pat_word[i]) : pat_data[i];
            check_way("hit_way_o", i, hit_way, pat_hit[i]);
            check_data("rd_data_o", i, rd_data, exp_data);
            last_hit = pat_hit[i];
        end else if (pat_op[i] == OP_REFILL) begin
            // Busy only in the write cycle of the refill
            check_ready("ready_o", i, ready, 1'b0);
            @(posedge clk);
            #2;
            check_ready("ready_o", i, ready, 1'b1);
        end
    endtask

    initial begin
        int low_cycles;
        seed        = 88;
        loaded      = 1'b0;
        rst_n       = 1'b0;
        lookup      = 1'b0;
        write       = 1'b0;
        refill      = 1'b0;
        set_idx     = '0;
        tag         = '0;
        word_idx    = '0;
        wr_data     = '0;
        wr_be       = '0;
        refill_line = '0;
        last_hit    = '0;
        for (int s = 0; s < NUM_SETS; s++) begin
            vld[s] = '0;
            rr[s]  = 0;
        end
        load_patterns();
        loaded = 1'b1;
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;
        // Directory sweep takes one cycle per set
        low_cycles = 0;
        while (!ready) begin
            low_cycles++;
            @(posedge clk);
            #2;
        end
        if (low_cycles != NUM_SETS) begin
            $display("mismatch ready_o low cycles: got 0x%h expected 0x%h", low_cycles, NUM_SETS);
            abort_run();
        end
        for (int i = 0; i < num_pat; i++) begin
            run_pattern(i);
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

    initial begin
        wait (loaded === 1'b1);
        #((num_pat * 4 + NUM_SETS + 20) * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles", num_pat * 4 + NUM_SETS + 20);
        abort_run();
    end

endmodule

`default_nettype wire

// File: logic/cache_memctrl_top.sv
// Cache directory and data controller top level, instantiated by the testbench as the DUT
`timescale 1ns/1ps
`default_nettype none

module cache_memctrl_top
    import memctrl_pkg::*;
(
    input  wire logic       clk_i,
    input  wire logic       rst_ni,
    output logic            ready_o,
    input  wire logic       lookup_i,
    input  wire logic       write_i,
    input  wire logic       refill_i,
    input  wire set_t       set_i,
    input  wire tag_t       tag_i,
    input  wire word_idx_t  word_i,
    input  wire data_word_t wr_data_i,
    input  wire word_be_t   wr_be_i,
    input  wire line_t      refill_line_i,
    output way_vec_t        hit_way_o,
    output data_word_t      rd_data_o
);

    logic     sweep;
    set_t     sweep_set;
    logic     refill_wr;
    way_vec_t victim;

    memctrl_fsm u_fsm (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .refill_i    (refill_i),
        .ready_o     (ready_o),
        .sweep_o     (sweep),
        .sweep_set_o (sweep_set),
        .refill_wr_o (refill_wr)
    );

    dir_ctrl u_dir_ctrl (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .sweep_i     (sweep),
        .sweep_set_i (sweep_set),
        .lookup_i    (lookup_i),
        .refill_i    (refill_i),
        .refill_wr_i (refill_wr),
        .set_i       (set_i),
        .tag_i       (tag_i),
        .hit_way_o   (hit_way_o),
        .victim_o    (victim)
    );

    data_ctrl u_data_ctrl (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .lookup_i      (lookup_i),
        .write_i       (write_i),
        .refill_i      (refill_i),
        .refill_wr_i   (refill_wr),
        .set_i         (set_i),
        .word_i        (word_i),
        .wr_data_i     (wr_data_i),
        .wr_be_i       (wr_be_i),
        .refill_line_i (refill_line_i),
        .hit_way_i     (hit_way_o),
        .victim_i      (victim),
        .rd_data_o     (rd_data_o)
    );

endmodule

`default_nettype wire

// File: logic/data_ctrl.sv
// Data array: per-way line RAMs, word write lanes, refill line write and read word select
`timescale 1ns/1ps
`default_nettype none

module data_ctrl
    import memctrl_pkg::*;
(
    input  wire logic       clk_i,
    input  wire logic       rst_ni,
    input  wire logic       lookup_i,
    input  wire logic       write_i,
    input  wire logic       refill_i,
    input  wire logic       refill_wr_i,
    input  wire set_t       set_i,
    input  wire word_idx_t  word_i,
    input  wire data_word_t wr_data_i,
    input  wire word_be_t   wr_be_i,
    input  wire line_t      refill_line_i,
    input  wire way_vec_t   hit_way_i,
    input  wire way_vec_t   victim_i,
    output data_word_t      rd_data_o
);

    set_t     data_addr;
    way_vec_t data_cs;
    way_vec_t data_we;
    line_t    data_wdata;
    line_be_t data_be;
    line_t    data_rdata [NUM_WAYS];

    word_idx_t word_q;
    line_t     refill_line_q;
    set_t      refill_set_q;

    always_comb begin
        data_addr  = set_i;
        data_cs    = '0;
        data_we    = '0;
        data_wdata = {LINE_WORDS{wr_data_i}};
        data_be    = line_be_t'(wr_be_i) << (word_i * (WORD_W / 8));
        if (refill_wr_i) begin
            // Whole line into the victim way
            data_addr  = refill_set_q;
            data_cs    = victim_i;
            data_we    = victim_i;
            data_wdata = refill_line_q;
            data_be    = '1;
        end else if (write_i) begin
            // Only the way hit by the latest lookup
            data_cs = hit_way_i;
            data_we = hit_way_i;
        end else if (lookup_i) begin
            data_cs = '1;
        end
    end

    for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_data_way
        cache_sram #(
            .DATA_W ($bits(line_t)),
            .ADDR_W ($bits(set_t))
        ) u_data_ram (
            .clk_i   (clk_i),
            .cs_i    (data_cs[w]),
            .we_i    (data_we[w]),
            .addr_i  (data_addr),
            .wdata_i (data_wdata),
            .be_i    (data_be),
            .rdata_o (data_rdata[w])
        );
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            word_q <= '0;
        end else if (lookup_i) begin
            word_q <= word_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (refill_i) begin
            refill_line_q <= refill_line_i;
            refill_set_q  <= set_i;
        end
    end

    // One-hot select, zero on a miss
    always_comb begin
        rd_data_o = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            rd_data_o |= data_rdata[w][word_q*WORD_W +: WORD_W] & {WORD_W{hit_way_i[w]}};
        end
    end

endmodule

`default_nettype wire

// File: logic/dir_ctrl.sv
// Tag directory: per-way entry RAMs, access mux, tag compare and victim selection
`timescale 1ns/1ps
`default_nettype none

module dir_ctrl
    import memctrl_pkg::*;
(
    input  wire logic     clk_i,
    input  wire logic     rst_ni,
    input  wire logic     sweep_i,
    input  wire set_t     sweep_set_i,
    input  wire logic     lookup_i,
    input  wire logic     refill_i,
    input  wire logic     refill_wr_i,
    input  wire set_t     set_i,
    input  wire tag_t     tag_i,
    output way_vec_t      hit_way_o,
    output way_vec_t      victim_o
);

    set_t       dir_addr;
    way_vec_t   dir_cs;
    way_vec_t   dir_we;
    dir_entry_t dir_wdata;
    dir_entry_t dir_rdata [NUM_WAYS];
    way_vec_t   dir_valid;
    way_vec_t   tag_match;

    tag_t lookup_tag_q;
    logic lookup_q;
    set_t refill_set_q;
    tag_t refill_tag_q;

    // Priority: sweep, lookup, refill read, refill write
    always_comb begin
        dir_addr  = set_i;
        dir_cs    = '0;
        dir_we    = '0;
        dir_wdata = '0;
        if (sweep_i) begin
            dir_addr = sweep_set_i;
            dir_cs   = '1;
            dir_we   = '1;
        end else if (lookup_i || refill_i) begin
            dir_cs = '1;
        end else if (refill_wr_i) begin
            dir_addr  = refill_set_q;
            dir_cs    = victim_o;
            dir_we    = victim_o;
            dir_wdata = {1'b1, refill_tag_q};
        end
    end

    for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_dir_way
        cache_sram #(
            .DATA_W ($bits(dir_entry_t)),
            .ADDR_W ($bits(set_t))
        ) u_dir_ram (
            .clk_i   (clk_i),
            .cs_i    (dir_cs[w]),
            .we_i    (dir_we[w]),
            .addr_i  (dir_addr),
            .wdata_i (dir_wdata),
            .be_i    (1'b1),
            .rdata_o (dir_rdata[w])
        );

        assign dir_valid[w] = dir_rdata[w][TAG_W];
        assign tag_match[w] = dir_valid[w] && (dir_rdata[w][TAG_W-1:0] == lookup_tag_q);
    end

    // Hit vector only means something after a lookup
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            lookup_q <= 1'b0;
        end else if (lookup_i) begin
            lookup_q <= 1'b1;
        end else if (refill_i || sweep_i) begin
            lookup_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (lookup_i) begin
            lookup_tag_q <= tag_i;
        end
        if (refill_i) begin
            refill_set_q <= set_i;
            refill_tag_q <= tag_i;
        end
    end

    assign hit_way_o = lookup_q ? tag_match : '0;

    victim_select u_victim_select (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .set_i     (refill_set_q),
        .valid_i   (dir_valid),
        .advance_i (refill_wr_i),
        .victim_o  (victim_o)
    );

endmodule

`default_nettype wire

// File: logic/victim_select.sv
// Victim way choice for refills: lowest invalid way, else per-set round-robin pointer
`timescale 1ns/1ps
`default_nettype none

module victim_select
    import memctrl_pkg::*;
(
    input  wire logic     clk_i,
    input  wire logic     rst_ni,
    input  wire set_t     set_i,
    input  wire way_vec_t valid_i,
    input  wire logic     advance_i,
    output way_vec_t      victim_o
);

    localparam int PTR_W = $clog2(NUM_WAYS);

    logic [PTR_W-1:0] rr_ptr_q [NUM_SETS];
    way_vec_t         invalid;
    way_vec_t         first_invalid;
    logic             all_valid;

    assign invalid   = ~valid_i;
    assign all_valid = &valid_i;

    // Isolate lowest set bit
    assign first_invalid = invalid & (~invalid + 1'b1);

    assign victim_o = all_valid ? way_vec_t'(1) << rr_ptr_q[set_i] : first_invalid;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                rr_ptr_q[s] <= '0;
            end
        end else if (advance_i && all_valid) begin
            // Wraps back to way 0 after the last way
            rr_ptr_q[set_i] <= rr_ptr_q[set_i] + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: logic/memctrl_fsm.sv
// Controller FSM: directory sweep after reset, idle and one-cycle refill write phase
`timescale 1ns/1ps
`default_nettype none

module memctrl_fsm
    import memctrl_pkg::*;
(
    input  wire logic clk_i,
    input  wire logic rst_ni,
    input  wire logic refill_i,
    output logic      ready_o,
    output logic      sweep_o,
    output set_t      sweep_set_o,
    output logic      refill_wr_o
);

    ctrl_state_t state_q, state_d;
    set_t        init_set_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_INIT: begin
                // Last set written this cycle
                if (init_set_q == set_t'(NUM_SETS - 1)) begin
                    state_d = ST_IDLE;
                end
            end
            ST_IDLE: begin
                if (refill_i) begin
                    state_d = ST_REFILL;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= ST_INIT;
            init_set_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == ST_INIT) begin
                init_set_q <= init_set_q + 1'b1;
            end
        end
    end

    assign ready_o     = (state_q == ST_IDLE);
    assign sweep_o     = (state_q == ST_INIT);
    assign sweep_set_o = init_set_q;
    assign refill_wr_o = (state_q == ST_REFILL);

endmodule

`default_nettype wire

// File: logic/cache_sram.sv
// Single-port RAM with byte-masked write and registered read, for directory and data ways
`timescale 1ns/1ps
`default_nettype none

module cache_sram #(
    parameter int DATA_W = 32,
    parameter int ADDR_W = 4,
    // Narrow odd widths (directory entries) get a single enable
    parameter int BE_W   = (DATA_W % 8 == 0) ? DATA_W / 8 : 1
) (
    input  wire logic              clk_i,
    input  wire logic              cs_i,
    input  wire logic              we_i,
    input  wire logic [ADDR_W-1:0] addr_i,
    input  wire logic [DATA_W-1:0] wdata_i,
    input  wire logic [BE_W-1:0]   be_i,
    output logic      [DATA_W-1:0] rdata_o
);

    localparam int LANE_W = DATA_W / BE_W;

    logic [DATA_W-1:0] mem_q [2**ADDR_W];

    always_ff @(posedge clk_i) begin
        if (cs_i) begin
            if (we_i) begin
                for (int b = 0; b < BE_W; b++) begin
                    if (be_i[b]) begin
                        mem_q[addr_i][b*LANE_W +: LANE_W] <= wdata_i[b*LANE_W +: LANE_W];
                    end
                end
            end else begin
                // Read data holds until the next read
                rdata_o <= mem_q[addr_i];
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/memctrl_pkg.sv
// Cache geometry, shared vector types and controller states, imported by the RTL and testbench
`default_nettype none

package memctrl_pkg;

    // Cache geometry
    localparam int NUM_WAYS   = 4;
    localparam int NUM_SETS   = 16;
    localparam int LINE_WORDS = 4;
    localparam int WORD_W     = 32;
    localparam int TAG_W      = 8;

    typedef logic [$clog2(NUM_SETS)-1:0]   set_t;
    typedef logic [TAG_W-1:0]              tag_t;
    typedef logic [$clog2(LINE_WORDS)-1:0] word_idx_t;
    typedef logic [NUM_WAYS-1:0]           way_vec_t;
    typedef logic [WORD_W-1:0]             data_word_t;
    typedef logic [WORD_W/8-1:0]           word_be_t;
    typedef logic [LINE_WORDS*WORD_W-1:0]  line_t;
    typedef logic [LINE_WORDS*WORD_W/8-1:0] line_be_t;

    // Valid bit on top, tag below
    typedef logic [TAG_W:0] dir_entry_t;

    typedef enum logic [1:0] {
        ST_INIT,
        ST_IDLE,
        ST_REFILL
    } ctrl_state_t;

endpackage

`default_nettype wire
